// File: include/ex_config.svh
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

// datapath
`define EX_XLEN         32
`define EX_REG_ADDR_W   5
`define EX_SHAMT_W      5

// result queue entries, also the issue credits upstream starts with
`define EX_QUEUE_DEPTH  4

// credits granted by downstream after reset
`define EX_RES_CREDITS  2

`endif

// File: hw/ex_pkg.sv
`include "ex_config.svh"

package ex_pkg;

    // opcodes kept by the execute stage
    parameter logic [6:0] OP_IMM    = 7'b0010011;
    parameter logic [6:0] OP_REG    = 7'b0110011;
    parameter logic [6:0] OP_BRANCH = 7'b1100011;
    parameter logic [6:0] OP_JAL    = 7'b1101111;
    parameter logic [6:0] OP_JALR   = 7'b1100111;
    parameter logic [6:0] OP_LUI    = 7'b0110111;
    parameter logic [6:0] OP_AUIPC  = 7'b0010111;

    // funct3, alu group
    parameter logic [2:0] F3_ADD_SUB = 3'b000;
    parameter logic [2:0] F3_SLL     = 3'b001;
    parameter logic [2:0] F3_SLT     = 3'b010;
    parameter logic [2:0] F3_SLTU    = 3'b011;
    parameter logic [2:0] F3_XOR     = 3'b100;
    parameter logic [2:0] F3_SR      = 3'b101; // srl/sra by bit 30
    parameter logic [2:0] F3_OR      = 3'b110;
    parameter logic [2:0] F3_AND     = 3'b111;

    // funct3, branch group
    parameter logic [2:0] F3_BEQ  = 3'b000;
    parameter logic [2:0] F3_BNE  = 3'b001;
    parameter logic [2:0] F3_BLT  = 3'b100;
    parameter logic [2:0] F3_BGE  = 3'b101;
    parameter logic [2:0] F3_BLTU = 3'b110;
    parameter logic [2:0] F3_BGEU = 3'b111;

    typedef union packed {
        struct packed {
            logic [6:0]                funct7;
            logic [`EX_REG_ADDR_W-1:0] rs2;
            logic [`EX_REG_ADDR_W-1:0] rs1;
            logic [2:0]                funct3;
            logic [`EX_REG_ADDR_W-1:0] rd;
            logic [6:0]                opcode;
        } r_fmt;
        struct packed {
            logic [11:0]               imm;    // low bits double as shamt
            logic [`EX_REG_ADDR_W-1:0] rs1;
            logic [2:0]                funct3;
            logic [`EX_REG_ADDR_W-1:0] rd;
            logic [6:0]                opcode;
        } i_fmt;
    } inst_u;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_OR,
        ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA, ALU_ZERO
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_ALWAYS
    } br_cond_e;

endpackage

// File: hw/ex_ifs.sv
`include "ex_config.svh"

// decoded operation, registered by the decode stage
interface ex_op_if import ex_pkg::*; ();
    logic                      valid;
    alu_op_e                   alu_op;
    br_cond_e                  br_cond;
    logic                      shamt_src;  // 1: shamt from instruction, 0: from reg2
    logic [`EX_XLEN-1:0]       op1;
    logic [`EX_XLEN-1:0]       op2;
    logic [`EX_XLEN-1:0]       op1_jump;
    logic [`EX_XLEN-1:0]       op2_jump;
    logic [`EX_XLEN-1:0]       reg1;
    logic [`EX_XLEN-1:0]       reg2;
    inst_u                     inst;
    logic                      reg_we;
    logic [`EX_REG_ADDR_W-1:0] rd;

    modport src (
        output valid, alu_op, br_cond, shamt_src, op1, op2, op1_jump, op2_jump,
        output reg1, reg2, inst, reg_we, rd
    );

    modport alu (input alu_op, shamt_src, op1, op2, reg1, reg2, inst);

    modport br (input br_cond, op1, op2, op1_jump, op2_jump);
endinterface

// one result on its way into the queue
interface ex_res_if ();
    logic                      valid;
    logic                      reg_we;
    logic [`EX_REG_ADDR_W-1:0] rd;
    logic [`EX_XLEN-1:0]       wdata;
    logic                      jump;
    logic [`EX_XLEN-1:0]       jump_addr;

    modport src (output valid, reg_we, rd);

    modport alu_src (output wdata);

    modport br_src (output jump, jump_addr);

    modport sink (input valid, reg_we, rd, wdata, jump, jump_addr);
endinterface

// File: hw/ex_decode_stage.sv
`include "ex_config.svh"

module ex_decode_stage import ex_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      issue_valid_i,
    input  inst_u                     inst_i,
    input  logic [`EX_XLEN-1:0]       op1_i,
    input  logic [`EX_XLEN-1:0]       op2_i,
    input  logic [`EX_XLEN-1:0]       op1_jump_i,
    input  logic [`EX_XLEN-1:0]       op2_jump_i,
    input  logic [`EX_XLEN-1:0]       reg1_rdata_i,
    input  logic [`EX_XLEN-1:0]       reg2_rdata_i,
    input  logic                      reg_we_i,
    input  logic [`EX_REG_ADDR_W-1:0] reg_waddr_i,
    ex_op_if.src                      op,
    ex_res_if.src                     res
);

    alu_op_e  alu_op_d;
    br_cond_e br_cond_d;
    logic     shamt_src_d;

    function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt,
                                            input logic reg_form);
        alu_op_e sel;
        case (f3)
            F3_ADD_SUB: sel = (alt && reg_form) ? ALU_SUB : ALU_ADD; // no subi
            F3_SLL:     sel = ALU_SLL;
            F3_SLT:     sel = ALU_SLT;
            F3_SLTU:    sel = ALU_SLTU;
            F3_XOR:     sel = ALU_XOR;
            F3_SR:      sel = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      sel = ALU_OR;
            F3_AND:     sel = ALU_AND;
            default:    sel = ALU_ZERO;
        endcase
        return sel;
    endfunction

    always_comb begin
        alu_op_d    = ALU_ZERO;
        br_cond_d   = BR_NONE;
        shamt_src_d = 1'b0;
        case (inst_i.r_fmt.opcode)
            OP_IMM: begin
                // bit 30 seen as imm[10] in the i view
                alu_op_d    = alu_from_f3(inst_i.i_fmt.funct3, inst_i.i_fmt.imm[10], 1'b0);
                shamt_src_d = 1'b1;
            end
            OP_REG: alu_op_d = alu_from_f3(inst_i.r_fmt.funct3, inst_i.r_fmt.funct7[5], 1'b1);
            OP_BRANCH: begin
                case (inst_i.r_fmt.funct3)
                    F3_BEQ:  br_cond_d = BR_EQ;
                    F3_BNE:  br_cond_d = BR_NE;
                    F3_BLT:  br_cond_d = BR_LT;
                    F3_BGE:  br_cond_d = BR_GE;
                    F3_BLTU: br_cond_d = BR_LTU;
                    F3_BGEU: br_cond_d = BR_GEU;
                    default: br_cond_d = BR_NONE;
                endcase
            end
            OP_JAL, OP_JALR: begin
                alu_op_d  = ALU_ADD;   // link value
                br_cond_d = BR_ALWAYS;
            end
            OP_LUI, OP_AUIPC: alu_op_d = ALU_ADD;
            default: alu_op_d = ALU_ZERO;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            op.valid <= 1'b0;
        end else begin
            op.valid <= issue_valid_i;
        end
    end

    // issue register payload
    always_ff @(posedge clk) begin
        if (issue_valid_i) begin
            op.alu_op    <= alu_op_d;
            op.br_cond   <= br_cond_d;
            op.shamt_src <= shamt_src_d;
            op.op1       <= op1_i;
            op.op2       <= op2_i;
            op.op1_jump  <= op1_jump_i;
            op.op2_jump  <= op2_jump_i;
            op.reg1      <= reg1_rdata_i;
            op.reg2      <= reg2_rdata_i;
            op.inst      <= inst_i;
            op.reg_we    <= reg_we_i;
            op.rd        <= reg_waddr_i;
        end
    end

    assign res.valid  = op.valid;
    assign res.reg_we = op.reg_we; // passes through for every opcode
    assign res.rd     = op.rd;

endmodule

// File: hw/ex_alu.sv
`include "ex_config.svh"

module ex_alu import ex_pkg::*; (
    ex_op_if.alu      op,
    ex_res_if.alu_src res
);

    logic [`EX_SHAMT_W-1:0] shamt;
    logic [`EX_XLEN-1:0]    srl_res;
    logic [`EX_XLEN-1:0]    sra_fill;
    logic                   lt_signed;
    logic                   lt_unsigned;

    // immediate shifts take the amount from the instruction
    assign shamt = op.shamt_src ? op.inst.i_fmt.imm[`EX_SHAMT_W-1:0]
                                : op.reg2[`EX_SHAMT_W-1:0];

    assign srl_res  = op.reg1 >> shamt;
    assign sra_fill = ~({`EX_XLEN{1'b1}} >> shamt); // upper bits vacated by the shift

    assign lt_signed   = $signed(op.op1) < $signed(op.op2);
    assign lt_unsigned = op.op1 < op.op2;

    always_comb begin
        case (op.alu_op)
            ALU_ADD: begin
                res.wdata = op.op1 + op.op2;
            end
            ALU_SUB: begin
                res.wdata = op.op1 - op.op2;
            end
            ALU_SLT: begin
                res.wdata = {{(`EX_XLEN-1){1'b0}}, lt_signed};
            end
            ALU_SLTU: begin
                res.wdata = {{(`EX_XLEN-1){1'b0}}, lt_unsigned};
            end
            ALU_XOR: begin
                res.wdata = op.op1 ^ op.op2;
            end
            ALU_OR: begin
                res.wdata = op.op1 | op.op2;
            end
            ALU_AND: begin
                res.wdata = op.op1 & op.op2;
            end
            ALU_SLL: begin
                res.wdata = op.reg1 << shamt;
            end
            ALU_SRL: begin
                res.wdata = srl_res;
            end
            ALU_SRA: begin
                // sign fill only for negative values
                res.wdata = op.reg1[`EX_XLEN-1] ? (srl_res | sra_fill) : srl_res;
            end
            default: begin
                res.wdata = '0; // branches, unknown opcodes
            end
        endcase
    end

endmodule

// File: hw/ex_branch.sv
`include "ex_config.svh"

module ex_branch import ex_pkg::*; (
    ex_op_if.br      op,
    ex_res_if.br_src res
);

    logic eq;
    logic lt_signed;
    logic lt_unsigned;
    logic taken;

    assign eq          = op.op1 == op.op2;
    assign lt_signed   = $signed(op.op1) < $signed(op.op2);
    assign lt_unsigned = op.op1 < op.op2;

    always_comb begin
        case (op.br_cond)
            BR_EQ:     taken = eq;
            BR_NE:     taken = !eq;
            BR_LT:     taken = lt_signed;
            BR_GE:     taken = !lt_signed;
            BR_LTU:    taken = lt_unsigned;
            BR_GEU:    taken = !lt_unsigned;
            BR_ALWAYS: taken = 1'b1; // jal, jalr
            default:   taken = 1'b0;
        endcase
    end

    assign res.jump      = taken;
    assign res.jump_addr = taken ? (op.op1_jump + op.op2_jump) : '0;

endmodule

// File: hw/ex_result_queue.sv
`include "ex_config.svh"

module ex_result_queue (
    input  logic                      clk,
    input  logic                      rst_n_i,
    ex_res_if.sink                    res,
    input  logic                      res_credit_i,
    output logic                      res_valid_o,
    output logic                      res_reg_we_o,
    output logic [`EX_REG_ADDR_W-1:0] res_reg_waddr_o,
    output logic [`EX_XLEN-1:0]       res_reg_wdata_o,
    output logic                      res_jump_o,
    output logic [`EX_XLEN-1:0]       res_jump_addr_o,
    output logic                      issue_credit_o
);

    localparam int DEPTH = `EX_QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int CRD_W = $clog2(`EX_RES_CREDITS + 1);

    logic                      q_we    [DEPTH];
    logic [`EX_REG_ADDR_W-1:0] q_rd    [DEPTH];
    logic [`EX_XLEN-1:0]       q_wdata [DEPTH];
    logic                      q_jump  [DEPTH];
    logic [`EX_XLEN-1:0]       q_jaddr [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CRD_W-1:0] credit_cnt;
    logic             credit_ok;
    logic             push;
    logic             pop;

    assign push      = res.valid;
    assign credit_ok = (credit_cnt != '0) || res_credit_i; // arriving credit usable at once
    assign pop       = (count != '0) && credit_ok;

    always_ff @(posedge clk) begin
        if (push) begin
            q_we[wr_ptr]    <= res.reg_we;
            q_rd[wr_ptr]    <= res.rd;
            q_wdata[wr_ptr] <= res.wdata;
            q_jump[wr_ptr]  <= res.jump;
            q_jaddr[wr_ptr] <= res.jump_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credit_cnt <= CRD_W'(`EX_RES_CREDITS);
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            case ({res_credit_i, pop})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt; // returned and spent together
            endcase
        end
    end

    // head entry
    assign res_reg_we_o    = q_we[rd_ptr];
    assign res_reg_waddr_o = q_rd[rd_ptr];
    assign res_reg_wdata_o = q_wdata[rd_ptr];
    assign res_jump_o      = q_jump[rd_ptr];
    assign res_jump_addr_o = q_jaddr[rd_ptr];

    assign res_valid_o    = pop;
    assign issue_credit_o = pop; // freed entry goes back upstream

endmodule

// File: hw/ex_core.sv
`include "ex_config.svh"

module ex_core (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      issue_valid_i,
    input  logic [`EX_XLEN-1:0]       inst_i,
    input  logic [`EX_XLEN-1:0]       op1_i,
    input  logic [`EX_XLEN-1:0]       op2_i,
    input  logic [`EX_XLEN-1:0]       op1_jump_i,
    input  logic [`EX_XLEN-1:0]       op2_jump_i,
    input  logic [`EX_XLEN-1:0]       reg1_rdata_i,
    input  logic [`EX_XLEN-1:0]       reg2_rdata_i,
    input  logic                      reg_we_i,
    input  logic [`EX_REG_ADDR_W-1:0] reg_waddr_i,
    input  logic                      res_credit_i,
    output logic                      issue_credit_o,
    output logic                      res_valid_o,
    output logic                      res_reg_we_o,
    output logic [`EX_REG_ADDR_W-1:0] res_reg_waddr_o,
    output logic [`EX_XLEN-1:0]       res_reg_wdata_o,
    output logic                      res_jump_o,
    output logic [`EX_XLEN-1:0]       res_jump_addr_o
);

    ex_op_if  op_if ();
    ex_res_if res_if ();

    // issue register and decode
    ex_decode_stage decode_inst (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .issue_valid_i (issue_valid_i),
        .inst_i        (inst_i),
        .op1_i         (op1_i),
        .op2_i         (op2_i),
        .op1_jump_i    (op1_jump_i),
        .op2_jump_i    (op2_jump_i),
        .reg1_rdata_i  (reg1_rdata_i),
        .reg2_rdata_i  (reg2_rdata_i),
        .reg_we_i      (reg_we_i),
        .reg_waddr_i   (reg_waddr_i),
        .op            (op_if.src),
        .res           (res_if.src)
    );

    ex_alu alu_inst (
        .op  (op_if.alu),
        .res (res_if.alu_src)
    );

    ex_branch branch_inst (
        .op  (op_if.br),
        .res (res_if.br_src)
    );

    // in-order results, credits both ways
    ex_result_queue queue_inst (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .res             (res_if.sink),
        .res_credit_i    (res_credit_i),
        .res_valid_o     (res_valid_o),
        .res_reg_we_o    (res_reg_we_o),
        .res_reg_waddr_o (res_reg_waddr_o),
        .res_reg_wdata_o (res_reg_wdata_o),
        .res_jump_o      (res_jump_o),
        .res_jump_addr_o (res_jump_addr_o),
        .issue_credit_o  (issue_credit_o)
    );

endmodule

// File: tests/ex_core_asserts.sv
`include "ex_config.svh"

module ex_core_asserts #(
    parameter int CNT_W = $clog2(`EX_QUEUE_DEPTH + 1),
    parameter int CRD_W = $clog2(`EX_RES_CREDITS + 1)
) (
    input logic             clk,
    input logic             rst_n_i,
    input logic             push_i,
    input logic [CNT_W-1:0] count_i,
    input logic [CRD_W-1:0] credit_cnt_i,
    input logic             res_credit_i,
    input logic             res_valid_i,
    input logic             issue_credit_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int held; // downstream credits as seen from the ports alone

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            held <= `EX_RES_CREDITS;
        end else begin
            held <= held + int'(res_credit_i) - int'(res_valid_i);
        end
    end

    credit_bound: assert property (@(posedge clk) disable iff (!rst_n_i)
        credit_cnt_i <= CRD_W'(`EX_RES_CREDITS))
        else $error("downstream credit counter above its grant");

    no_push_full: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(push_i && count_i == CNT_W'(`EX_QUEUE_DEPTH)))
        else $error("push into a full result queue");

    // checked on every reset cycle, not only the last one
    quiet_after_reset: assert property (@(posedge clk)
        !rst_n_i |=> !res_valid_i && !issue_credit_i)
        else $error("result or issue credit right after reset");

    valid_has_credit: assert property (@(posedge clk) disable iff (!rst_n_i)
        res_valid_i |-> (held > 0 || res_credit_i))
        else $error("result sent without a downstream credit");

endmodule

bind ex_result_queue ex_core_asserts asserts_inst (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .push_i         (push),
    .count_i        (count),
    .credit_cnt_i   (credit_cnt),
    .res_credit_i   (res_credit_i),
    .res_valid_i    (res_valid_o),
    .issue_credit_i (issue_credit_o)
);

// File: tests/ex_core_tb.sv
`include "ex_config.svh"

module ex_core_tb import ex_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_ITEMS   = 400;
    localparam int MAX_CYCLE = N_ITEMS * 20 + 50;

    typedef struct packed {
        logic                      we;
        logic [`EX_REG_ADDR_W-1:0] rd;
        logic [`EX_XLEN-1:0]       wdata;
        logic                      jump;
        logic [`EX_XLEN-1:0]       addr;
    } result_t;

    logic                      clk = 1'b0;
    logic                      rst_n_i, issue_valid_i, res_credit_i, reg_we_i;
    logic [`EX_REG_ADDR_W-1:0] reg_waddr_i, res_reg_waddr_o;
    logic [`EX_XLEN-1:0]       inst_i, op1_i, op2_i, op1_jump_i, op2_jump_i;
    logic [`EX_XLEN-1:0]       reg1_rdata_i, reg2_rdata_i, res_reg_wdata_o, res_jump_addr_o;
    logic                      issue_credit_o, res_valid_o, res_reg_we_o, res_jump_o;

    result_t exp_q[$];
    integer  seed          = 17444;
    int      issue_credits = `EX_QUEUE_DEPTH;
    int      ds_pending    = 0;   // consumed, credit not yet returned
    int      n_issued      = 0;
    int      n_recv        = 0;
    int      n_valid       = 0;
    int      n_returned    = 0;
    int      cycles        = 0;
    int      data_errs     = 0;
    int      proto_errs    = 0;

    ex_core ex_core_inst (.*);

    always #50 clk = ~clk;

    function automatic result_t expected_result(input logic [31:0] inst, a, b, ja, jb, r1, r2,
                                                input logic we, input logic [4:0] rd);
        result_t            r;
        logic signed [31:0] as, bs, r1s;
        logic [4:0]         sh;
        logic               taken;
        as    = a;
        bs    = b;
        r1s   = r1;
        sh    = (inst[6:0] == OP_IMM) ? inst[24:20] : r2[4:0];
        taken = 1'b0;
        r     = '{we, rd, 32'd0, 1'b0, 32'd0};
        case (inst[6:0])
            OP_REG, OP_IMM: begin
                case (inst[14:12])
                    3'b000:  r.wdata = (inst[30] && inst[6:0] == OP_REG) ? a - b : a + b;
                    3'b001:  r.wdata = r1 << sh;
                    3'b010:  r.wdata = {31'd0, as < bs};
                    3'b011:  r.wdata = {31'd0, a < b};
                    3'b100:  r.wdata = a ^ b;
                    3'b101:  r.wdata = inst[30] ? $unsigned(r1s >>> sh) : r1 >> sh;
                    3'b110:  r.wdata = a | b;
                    default: r.wdata = a & b;
                endcase
            end
            OP_BRANCH: begin
                case (inst[14:12])
                    3'b000:  taken = a == b;
                    3'b001:  taken = a != b;
                    3'b100:  taken = as < bs;
                    3'b101:  taken = as >= bs;
                    3'b110:  taken = a < b;
                    3'b111:  taken = a >= b;
                    default: taken = 1'b0;
                endcase
            end
            OP_JAL, OP_JALR: begin
                r.wdata = a + b;
                taken   = 1'b1;
            end
            OP_LUI, OP_AUIPC: r.wdata = a + b;
            default: ;  // dropped opcodes write zero
        endcase
        r.jump = taken;
        r.addr = taken ? ja + jb : '0;
        return r;
    endfunction

    // operands as the decoder upstream would form them
    task automatic drive_item();
        logic [31:0] inst;
        logic [31:0] pc;
        logic [31:0] imm_i;
        int          kind;
        inst         = $random(seed);
        pc           = $random(seed) & 32'hffff_fffc;
        kind         = $random(seed) & 15;
        imm_i        = {{20{inst[31]}}, inst[31:20]};
        reg1_rdata_i = $random(seed);
        reg2_rdata_i = (($random(seed) & 3) == 0) ? reg1_rdata_i : $random(seed);
        reg_we_i     = 1'($random(seed));
        reg_waddr_i  = 5'($random(seed));
        op1_i        = reg1_rdata_i;
        op2_i        = reg2_rdata_i;
        op1_jump_i   = pc;
        op2_jump_i   = imm_i;
        case (kind)
            0, 1, 2, 3: inst[6:0] = OP_REG;
            4, 5, 6: begin
                inst[6:0] = OP_IMM;
                op2_i     = imm_i;
            end
            7, 8: inst[6:0] = OP_BRANCH;
            9, 10: begin
                inst[6:0] = (kind == 9) ? OP_JAL : OP_JALR;
                op1_i     = pc;     // link is pc + 4
                op2_i     = 32'd4;
                if (kind == 10) begin
                    op1_jump_i = reg1_rdata_i;
                end
            end
            11: begin
                inst[6:0] = OP_LUI;
                op1_i     = {inst[31:12], 12'd0};
                op2_i     = '0;
            end
            12: begin
                inst[6:0] = OP_AUIPC;
                op1_i     = pc;
                op2_i     = {inst[31:12], 12'd0};
            end
            default: begin
                // load, store, system
                inst[6:0] = (kind == 13) ? 7'b0000011 : (kind == 14) ? 7'b0100011 : 7'b1110011;
                op2_i     = $random(seed);
            end
        endcase
        inst_i        = inst;
        issue_valid_i = 1'b1;
        exp_q.push_back(expected_result(inst, op1_i, op2_i, op1_jump_i, op2_jump_i,
                                        reg1_rdata_i, reg2_rdata_i, reg_we_i, reg_waddr_i));
    endtask

    initial begin
        rst_n_i       = 1'b0;
        issue_valid_i = 1'b0;
        res_credit_i  = 1'b0;
        reg_we_i      = 1'b0;
        reg_waddr_i   = '0;
        inst_i        = '0;
        op1_i         = '0;
        op2_i         = '0;
        op1_jump_i    = '0;
        op2_jump_i    = '0;
        reg1_rdata_i  = '0;
        reg2_rdata_i  = '0;
        repeat (5) @(posedge clk);
        #1 rst_n_i = 1'b1;
        while (n_recv < N_ITEMS) begin
            @(posedge clk);
            #1;
            issue_valid_i = 1'b0;
            res_credit_i  = 1'b0;
            if (n_issued < N_ITEMS && issue_credits > 0 && ($random(seed) & 3) != 0) begin
                drive_item();
                issue_credits--;
                n_issued++;
            end
            if (ds_pending > 0 && ($random(seed) & 1)) begin
                res_credit_i = 1'b1;
                ds_pending--;
                n_returned++;
            end
        end
        @(posedge clk);
        #1 res_credit_i = 1'b0;
        repeat (4) @(posedge clk);
        assert (exp_q.size() == 0 && issue_credits == `EX_QUEUE_DEPTH) else begin
            proto_errs++;
            $display("error at %0d ns: %0d results missing, %0d issue credits held",
                     $time, exp_q.size(), issue_credits);
        end
        $display("error counts: %0d data, %0d protocol", data_errs, proto_errs);
        if (data_errs + proto_errs == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // mid-cycle, where outputs have settled
    always @(negedge clk) begin
        result_t got;
        result_t exp;
        if (rst_n_i) begin
            assert (issue_credit_o == res_valid_o) else begin
                proto_errs++;
                $display("error at %0d ns: issue credit and result valid differ", $time);
            end
            if (issue_credit_o) begin
                issue_credits++;
            end
            if (res_valid_o) begin
                n_valid++;
                ds_pending++;
                got = '{res_reg_we_o, res_reg_waddr_o, res_reg_wdata_o, res_jump_o,
                        res_jump_addr_o};
                assert (n_valid <= `EX_RES_CREDITS + n_returned) else begin
                    proto_errs++;
                    $display("error at %0d ns: result %0d without a credit", $time, n_valid);
                end
                assert (exp_q.size() > 0) else begin
                    proto_errs++;
                    $display("error at %0d ns: result with no item outstanding", $time);
                end
                if (exp_q.size() > 0) begin
                    exp = exp_q.pop_front();
                    assert (got == exp) else begin
                        data_errs++;
                        $display("error at %0d ns: item %0d got we=%b rd=%0d data=%h jump=%b addr=%h",
                                 $time, n_recv, got.we, got.rd, got.wdata, got.jump, got.addr);
                        $display("error at %0d ns: item %0d exp we=%b rd=%0d data=%h jump=%b addr=%h",
                                 $time, n_recv, exp.we, exp.rd, exp.wdata, exp.jump, exp.addr);
                    end
                end
                n_recv++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLE) begin
            $display("run timed out after %0d cycles with %0d of %0d results received",
                     MAX_CYCLE, n_recv, N_ITEMS);
            $display("Simulation failed");
            $finish;
        end
    end

endmodule

// File: files.f
+incdir+include
hw/ex_pkg.sv
hw/ex_ifs.sv
hw/ex_decode_stage.sv
hw/ex_alu.sv
hw/ex_branch.sv
hw/ex_result_queue.sv
hw/ex_core.sv
tests/ex_core_asserts.sv
tests/ex_core_tb.sv
